/* design/shelf_pkg.sv */
package shelf_pkg;

    typedef logic [9:0]  coord_t;
    typedef logic [7:0]  bound_t;
    typedef logic [31:0] rect_t;
    typedef logic [7:0]  area_t;
    typedef logic [7:0]  amount_t;
    typedef logic [7:0]  user_t;

    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_RED,
        CLS_GREEN,
        CLS_BLUE,
        CLS_YELLOW,
        CLS_BLACK,
        CLS_WHITE
    } color_class_t;

    typedef enum logic [3:0] {
        LBL_NONE      = 4'd0,
        LBL_GREEN     = 4'd1,
        LBL_BLUE      = 4'd2,
        LBL_YELLOW    = 4'd3,
        LBL_RED_DARK  = 4'd4,
        LBL_RED_WIDE  = 4'd5,
        LBL_RED_TALL  = 4'd6,
        LBL_RED_PLAIN = 4'd7
    } label_t;

    typedef enum logic [2:0] {
        ST_FREE = 3'd0,
        ST_GET  = 3'd1,
        ST_PUT  = 3'd2,
        ST_PAY  = 3'd3,
        ST_WARN = 3'd4
    } checkout_state_t;

    localparam user_t USER_NOBODY  = 8'h00;
    localparam user_t USER_RESTOCK = 8'hFF;

    // areas in samples, one sample per 8x8 pixels
    localparam area_t COLOR_AREA_MIN = 8'd32;
    localparam area_t DARK_AREA_MIN  = 8'd8;
    localparam int    TALL_MARGIN    = 24;

    function automatic amount_t label_price(label_t lbl);
        case (lbl)
            LBL_GREEN, LBL_BLUE, LBL_YELLOW, LBL_RED_PLAIN: return 8'd2;
            LBL_RED_DARK: return 8'd4;
            LBL_RED_WIDE: return 8'd3;
            LBL_RED_TALL: return 8'd6;
            default:      return 8'd0;
        endcase
    endfunction

endpackage

/* design/pix_if.sv */
interface pix_if
    import shelf_pkg::*;
();

    logic         valid;
    coord_t       x;
    coord_t       y;
    color_class_t cls;
    logic         in_win;
    logic         win_first;
    logic         win_last;

    modport src (
        output valid, x, y, cls, in_win, win_first, win_last
    );

    modport snk (
        input  valid, x, y, cls, in_win, win_first, win_last
    );

endinterface

/* design/label_if.sv */
interface label_if
    import shelf_pkg::*;
#(
    parameter int N_RECT = 16
)();

    // four-phase req/ack, labels frozen while either is high
    logic   req;
    logic   ack;
    label_t labels [N_RECT];

    modport src (
        output req, labels,
        input  ack
    );

    modport snk (
        input  req, labels,
        output ack
    );

endinterface

/* design/frame_scan.sv */
module frame_scan
    import shelf_pkg::*;
#(
    parameter int FRAME_W = 640,
    parameter int FRAME_H = 480,
    parameter int WIN_X1  = 80,
    parameter int WIN_X2  = 559,
    parameter int WIN_Y1  = 40,
    parameter int WIN_Y2  = 439
)(
    input  logic         sys_clk,
    input  logic         sys_rst_n,
    input  logic         i_valid,
    input  color_class_t i_class,
    pix_if.src           pix
);

    coord_t cnt_x;
    coord_t cnt_y;
    logic   x_in;
    logic   y_in;

    // position of the pixel now at the input
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (sys_rst_n == 1'b0) begin
            cnt_x <= '0;
            cnt_y <= '0;
        end else if (i_valid) begin
            if (cnt_x == coord_t'(FRAME_W - 1)) begin
                cnt_x <= '0;
                if (cnt_y == coord_t'(FRAME_H - 1))
                    cnt_y <= '0;
                else
                    cnt_y <= cnt_y + 1'b1;
            end else begin
                cnt_x <= cnt_x + 1'b1;
            end
        end
    end

    assign x_in = cnt_x >= coord_t'(WIN_X1) && cnt_x <= coord_t'(WIN_X2);
    assign y_in = cnt_y >= coord_t'(WIN_Y1) && cnt_y <= coord_t'(WIN_Y2);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (sys_rst_n == 1'b0) begin
            pix.valid     <= 1'b0;
            pix.in_win    <= 1'b0;
            pix.win_first <= 1'b0;
            pix.win_last  <= 1'b0;
        end else begin
            pix.valid     <= i_valid;
            pix.in_win    <= x_in && y_in;
            pix.win_first <= i_valid && cnt_x == coord_t'(WIN_X1) && cnt_y == coord_t'(WIN_Y1);
            pix.win_last  <= i_valid && cnt_x == coord_t'(WIN_X2) && cnt_y == coord_t'(WIN_Y2);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (i_valid) begin
            pix.x   <= cnt_x;
            pix.y   <= cnt_y;
            pix.cls <= i_class;
        end
    end

    a_first_last_apart: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !(pix.win_first && pix.win_last));

endmodule

/* design/item_grader.sv */
module item_grader
    import shelf_pkg::*;
#(
    parameter int N_RECT = 16
)(
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic [N_RECT*32-1:0] i_rects,
    pix_if.snk                   pix,
    label_if.src                 lbl
);

    logic       sample;
    logic       cls_ok;
    logic [2:0] cidx;
    logic       accept;

    // one sample per 8x8 pixel block
    assign sample = pix.valid && pix.in_win && pix.x[2:0] == 3'd0 && pix.y[2:0] == 3'd0;
    assign cls_ok = pix.cls != CLS_NONE && pix.cls <= CLS_WHITE;
    // area slot is the class minus one
    assign cidx   = pix.cls - 3'd1;

    // a frame ending mid-handshake is dropped
    assign accept = pix.win_last && !lbl.req && !lbl.ack;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (sys_rst_n == 1'b0)
            lbl.req <= 1'b0;
        else if (accept)
            lbl.req <= 1'b1;
        else if (lbl.ack)
            lbl.req <= 1'b0;
    end

    //**********************************************************************
    // per rectangle slot
    //**********************************************************************
    for (genvar k = 0; k < N_RECT; k++) begin : g_slot
        rect_t  rect_q;
        rect_t  rect_cur;
        area_t  area_q [6];
        bound_t dx;
        bound_t dy;
        logic   hit;
        logic   red;
        logic   green;
        logic   blue;
        logic   yellow;
        logic   dark;
        logic   wide;
        logic   tall;
        logic   plain;
        label_t grade;

        // first window pixel uses the rectangle being latched
        assign rect_cur = pix.win_first ? i_rects[k*32 +: 32] : rect_q;

        // bounds are in units of 4 pixels
        assign hit = sample && cls_ok
            && pix.x[9:2] >= rect_cur[31:24] && pix.x[9:2] <= rect_cur[15:8]
            && pix.y[9:2] >= rect_cur[23:16] && pix.y[9:2] <= rect_cur[7:0];

        always_ff @(posedge sys_clk) begin
            if (pix.win_first) begin
                rect_q <= i_rects[k*32 +: 32];
                for (int c = 0; c < 6; c++)
                    area_q[c] <= '0;
                if (hit)
                    area_q[cidx] <= 8'd1;
            end else if (hit && area_q[cidx] != 8'hFF) begin
                area_q[cidx] <= area_q[cidx] + 1'b1;
            end
        end

        assign red    = area_q[0] > COLOR_AREA_MIN;
        assign green  = area_q[1] > COLOR_AREA_MIN;
        assign blue   = area_q[2] > COLOR_AREA_MIN;
        assign yellow = area_q[3] > COLOR_AREA_MIN;
        assign dark   = area_q[4] > DARK_AREA_MIN;

        assign dx    = rect_q[15:8] - rect_q[31:24];
        assign dy    = rect_q[7:0] - rect_q[23:16];
        assign wide  = dx >= dy;
        assign tall  = {1'b0, dx} + 9'(TALL_MARGIN) <= {1'b0, dy};
        assign plain = !wide && !tall;

        always_comb begin
            if (red && tall)
                grade = LBL_RED_TALL;
            else if (green)
                grade = LBL_GREEN;
            else if (blue)
                grade = LBL_BLUE;
            else if (yellow)
                grade = LBL_YELLOW;
            else if (red && dark)
                grade = LBL_RED_DARK;
            else if (red && wide)
                grade = LBL_RED_WIDE;
            else if (red && plain)
                grade = LBL_RED_PLAIN;
            else
                grade = LBL_NONE;
        end

        always_ff @(posedge sys_clk or negedge sys_rst_n) begin
            if (sys_rst_n == 1'b0)
                lbl.labels[k] <= LBL_NONE;
            else if (accept)
                lbl.labels[k] <= grade;
        end

        a_label_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
            (lbl.req || lbl.ack) |=> $stable(lbl.labels[k]));
    end

endmodule

/* design/label_tally.sv */
module label_tally
    import shelf_pkg::*;
#(
    parameter int N_RECT = 16
)(
    input  logic    sys_clk,
    input  logic    sys_rst_n,
    label_if.snk    lbl,
    output logic    o_tally_valid,
    output amount_t o_tally_num,
    output amount_t o_tally_money
);

    localparam int IW = (N_RECT > 1) ? $clog2(N_RECT) : 1;

    logic [IW-1:0] idx;
    logic          scan;
    label_t        cur;
    amount_t       num_acc;
    amount_t       money_acc;
    amount_t       num_next;
    amount_t       money_next;

    // one slot per cycle while req waits for ack
    assign scan       = lbl.req && !lbl.ack;
    assign cur        = lbl.labels[idx];
    assign num_next   = num_acc + amount_t'(cur != LBL_NONE);
    assign money_next = money_acc + label_price(cur);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (sys_rst_n == 1'b0) begin
            idx           <= '0;
            num_acc       <= '0;
            money_acc     <= '0;
            lbl.ack       <= 1'b0;
            o_tally_valid <= 1'b0;
            o_tally_num   <= '0;
            o_tally_money <= '0;
        end else begin
            o_tally_valid <= 1'b0;
            if (!lbl.req)
                lbl.ack <= 1'b0;
            if (scan) begin
                if (idx == IW'(N_RECT - 1)) begin
                    idx           <= '0;
                    num_acc       <= '0;
                    money_acc     <= '0;
                    lbl.ack       <= 1'b1;
                    o_tally_valid <= 1'b1;
                    o_tally_num   <= num_next;
                    o_tally_money <= money_next;
                end else begin
                    idx       <= idx + 1'b1;
                    num_acc   <= num_next;
                    money_acc <= money_next;
                end
            end
        end
    end

    a_ack_needs_req: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $rose(lbl.ack) |-> lbl.req);

endmodule

/* design/checkout_fsm.sv */
module checkout_fsm
    import shelf_pkg::*;
#(
    parameter int HOLD_CYCLES    = 130_000_000,
    parameter int UNSTABLE_LIMIT = 50
)(
    input  logic            sys_clk,
    input  logic            sys_rst_n,
    input  logic            i_tally_valid,
    input  amount_t         i_tally_num,
    input  amount_t         i_tally_money,
    input  user_t           i_user,
    output amount_t         o_num,
    output amount_t         o_money,
    output amount_t         o_payment,
    output user_t           o_user,
    output checkout_state_t o_state
);

    logic [31:0] hold_cnt;
    logic [7:0]  unstable_cnt;
    amount_t     num_saved;
    amount_t     money_saved;
    logic        hold_done;

    // time spent showing a payment or a warning
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (sys_rst_n == 1'b0)
            hold_cnt <= '0;
        else if (o_state == ST_PAY || o_state == ST_WARN)
            hold_cnt <= hold_cnt + 1'b1;
        else
            hold_cnt <= '0;
    end

    assign hold_done = hold_cnt > 32'(HOLD_CYCLES);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (sys_rst_n == 1'b0) begin
            unstable_cnt <= '0;
            num_saved    <= '0;
            money_saved  <= '0;
            o_num        <= '0;
            o_money      <= '0;
            o_payment    <= '0;
            o_user       <= '0;
            o_state      <= ST_FREE;
        end else if (i_tally_valid) begin
            if (unstable_cnt > 8'(UNSTABLE_LIMIT)) begin
                unstable_cnt <= '0;
                o_num        <= i_tally_num;
                o_money      <= i_tally_money;
                o_payment    <= '0;
                o_state      <= ST_WARN;
            end else begin
                case (o_state)
                    ST_FREE: begin
                        if (i_tally_num != o_num) begin
                            unstable_cnt <= unstable_cnt + 1'b1;
                        end else if (i_user == USER_RESTOCK) begin
                            o_state <= ST_PUT;
                        end else if (i_user != USER_NOBODY) begin
                            num_saved   <= o_num;
                            money_saved <= o_money;
                            o_user      <= i_user;
                            o_state     <= ST_GET;
                        end else begin
                            // settled shelf, let the counter decay
                            if (unstable_cnt != 8'd0)
                                unstable_cnt <= unstable_cnt - 1'b1;
                            o_num     <= i_tally_num;
                            o_money   <= i_tally_money;
                            o_payment <= '0;
                        end
                    end
                    ST_GET: begin
                        if (i_user == USER_NOBODY) begin
                            o_num     <= num_saved;
                            o_money   <= money_saved;
                            o_payment <= money_saved - i_tally_money;
                            o_state   <= ST_PAY;
                        end
                    end
                    ST_PUT: begin
                        if (i_user == USER_NOBODY) begin
                            o_num   <= i_tally_num;
                            o_state <= ST_FREE;
                        end
                    end
                    ST_PAY, ST_WARN: begin
                        if (hold_done) begin
                            o_num   <= i_tally_num;
                            o_state <= ST_FREE;
                            if (o_state == ST_PAY)
                                o_user <= i_user;
                        end
                    end
                    default: o_state <= ST_FREE;
                endcase
            end
        end
    end

    a_state_legal: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        o_state inside {ST_FREE, ST_GET, ST_PUT, ST_PAY, ST_WARN});

endmodule

/* design/shelf_top.sv */
module shelf_top
    import shelf_pkg::*;
#(
    parameter int N_RECT         = 16,
    parameter int FRAME_W        = 640,
    parameter int FRAME_H        = 480,
    parameter int WIN_X1         = 80,
    parameter int WIN_X2         = 559,
    parameter int WIN_Y1         = 40,
    parameter int WIN_Y2         = 439,
    parameter int HOLD_CYCLES    = 130_000_000,
    parameter int UNSTABLE_LIMIT = 50
)(
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic                 i_valid,
    input  color_class_t         i_class,
    input  logic [N_RECT*32-1:0] i_rects,
    input  user_t                i_user,
    output logic [N_RECT*4-1:0]  o_labels,
    output amount_t              o_num,
    output amount_t              o_money,
    output amount_t              o_payment,
    output user_t                o_user,
    output checkout_state_t      o_state
);

    pix_if                      pix ();
    label_if #(.N_RECT(N_RECT)) lbl ();

    logic    tally_valid;
    amount_t tally_num;
    amount_t tally_money;

    frame_scan #(
        .FRAME_W (FRAME_W),
        .FRAME_H (FRAME_H),
        .WIN_X1  (WIN_X1),
        .WIN_X2  (WIN_X2),
        .WIN_Y1  (WIN_Y1),
        .WIN_Y2  (WIN_Y2)
    ) u_frame_scan (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .i_valid   (i_valid),
        .i_class   (i_class),
        .pix       (pix)
    );

    item_grader #(
        .N_RECT (N_RECT)
    ) u_item_grader (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .i_rects   (i_rects),
        .pix       (pix),
        .lbl       (lbl)
    );

    label_tally #(
        .N_RECT (N_RECT)
    ) u_label_tally (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .lbl           (lbl),
        .o_tally_valid (tally_valid),
        .o_tally_num   (tally_num),
        .o_tally_money (tally_money)
    );

    checkout_fsm #(
        .HOLD_CYCLES    (HOLD_CYCLES),
        .UNSTABLE_LIMIT (UNSTABLE_LIMIT)
    ) u_checkout_fsm (
        .sys_clk       (sys_clk),
        .sys_rst_n     (sys_rst_n),
        .i_tally_valid (tally_valid),
        .i_tally_num   (tally_num),
        .i_tally_money (tally_money),
        .i_user        (i_user),
        .o_num         (o_num),
        .o_money       (o_money),
        .o_payment     (o_payment),
        .o_user        (o_user),
        .o_state       (o_state)
    );

    // slot k in bits 4k+3:4k
    for (genvar k = 0; k < N_RECT; k++) begin : g_label_out
        assign o_labels[k*4 +: 4] = lbl.labels[k];
    end

endmodule

/* testbench/tb_shelf.sv */
module tb_shelf
    import shelf_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NR      = 4;
    localparam int FW      = 112;
    localparam int FH      = 112;
    localparam int WIN_LO  = 8;
    localparam int WIN_HI  = 103;
    localparam int TIMEOUT = 2000;

    // shelf pictures
    localparam int SC_FULL  = 0;
    localparam int SC_MIXED = 1;
    localparam int SC_TAKEN = 2;

    logic             sys_clk;
    logic             sys_rst_n;
    logic             i_valid;
    color_class_t     i_class;
    logic [NR*32-1:0] i_rects;
    user_t            i_user;
    logic [NR*4-1:0]  o_labels;
    amount_t          o_num;
    amount_t          o_money;
    amount_t          o_payment;
    user_t            o_user;
    checkout_state_t  o_state;

    logic [15:0]      lfsr;
    logic             check_en;
    logic             timed_out;
    string            test_name;
    logic [NR*4-1:0]  exp_labels;
    checkout_state_t  exp_state;
    amount_t          exp_num;
    amount_t          exp_money;
    amount_t          exp_payment;
    user_t            exp_user;
    amount_t          m_num;
    amount_t          m_money;
    int               frames_sent;
    int               tally_cnt;
    int               mismatches;
    int               timeouts;

    shelf_top #(
        .N_RECT         (NR),
        .FRAME_W        (FW),
        .FRAME_H        (FH),
        .WIN_X1         (WIN_LO),
        .WIN_X2         (WIN_HI),
        .WIN_Y1         (WIN_LO),
        .WIN_Y2         (WIN_HI),
        .HOLD_CYCLES    (40),
        .UNSTABLE_LIMIT (2)
    ) u_dut (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .i_valid   (i_valid),
        .i_class   (i_class),
        .i_rects   (i_rects),
        .i_user    (i_user),
        .o_labels  (o_labels),
        .o_num     (o_num),
        .o_money   (o_money),
        .o_payment (o_payment),
        .o_user    (o_user),
        .o_state   (o_state)
    );

    always #2 sys_clk = ~sys_clk;

    // one count per finished label scan
    always @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n)
            tally_cnt <= 0;
        else if (u_dut.tally_valid)
            tally_cnt <= tally_cnt + 1;
    end

    task automatic note_mismatch(string what, logic [31:0] exp, logic [31:0] act);
        mismatches++;
        $display("mismatch %s %s: expected %0h actual %0h", test_name, what, exp, act);
    endtask

    //**********************************************************************
    // output checks
    //**********************************************************************
    a_labels: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        check_en |-> o_labels == exp_labels)
        else note_mismatch("labels", $sampled(exp_labels), $sampled(o_labels));
    a_state: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        check_en |-> o_state == exp_state)
        else note_mismatch("state", $sampled(exp_state), $sampled(o_state));
    a_num: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        check_en |-> o_num == exp_num)
        else note_mismatch("num", $sampled(exp_num), $sampled(o_num));
    a_money: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        check_en |-> o_money == exp_money)
        else note_mismatch("money", $sampled(exp_money), $sampled(o_money));
    a_payment: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        check_en |-> o_payment == exp_payment)
        else note_mismatch("payment", $sampled(exp_payment), $sampled(o_payment));
    a_user: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        check_en |-> o_user == exp_user)
        else note_mismatch("user", $sampled(exp_user), $sampled(o_user));

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_class(output color_class_t c);
        logic [2:0] r;
        for (int b = 0; b < 3; b++) begin
            r[b] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        c = color_class_t'((r == 3'd7) ? 3'd0 : r);
    endtask

    function automatic amount_t item_price(logic [3:0] lbl);
        case (lbl)
            4'd1, 4'd2, 4'd3, 4'd7: return 8'd2;
            4'd4: return 8'd4;
            4'd5: return 8'd3;
            4'd6: return 8'd6;
            default: return 8'd0;
        endcase
    endfunction

    // bytes x1, y1, x2, y2 in units of 4 pixels
    function automatic rect_t rect_of(int scene, int k);
        if (scene == SC_MIXED) begin
            case (k)
                0: return {8'd2, 8'd2, 8'd12, 8'd12};
                1: return {8'd14, 8'd2, 8'd24, 8'd12};
                2: return {8'd2, 8'd14, 8'd24, 8'd25};
                default: return '0;
            endcase
        end
        case (k)
            0: return {8'd2, 8'd2, 8'd12, 8'd12};
            1: return {8'd14, 8'd2, 8'd80, 8'd12};
            2: return {8'd2, 8'd14, 8'd12, 8'd60};
            default: return {8'd14, 8'd14, 8'd24, 8'd40};
        endcase
    endfunction

    // colors inside the window, one item per quadrant
    function automatic color_class_t scene_class(int scene, int x, int y);
        if (y < 56) begin
            if (x < 56)
                return (scene == SC_MIXED) ? CLS_BLUE : CLS_GREEN;
            return (scene == SC_MIXED) ? CLS_YELLOW : CLS_RED;
        end
        if (scene == SC_MIXED)
            return (x < 24) ? CLS_BLACK : CLS_RED;
        if (scene == SC_TAKEN && x >= 56)
            return CLS_WHITE;
        return CLS_RED;
    endfunction

    task automatic build_model(int scene);
        int           cnt [6];
        rect_t        r;
        color_class_t cls;
        int           dx;
        int           dy;
        logic         red;
        logic         wide;
        logic         tall;
        logic [3:0]   lbl;
        m_num   = 0;
        m_money = 0;
        for (int k = 0; k < NR; k++) begin
            r = rect_of(scene, k);
            for (int c = 0; c < 6; c++)
                cnt[c] = 0;
            for (int y = WIN_LO; y <= WIN_HI; y += 8) begin
                for (int x = WIN_LO; x <= WIN_HI; x += 8) begin
                    cls = scene_class(scene, x, y);
                    if (cls != CLS_NONE && (x >> 2) >= r[31:24] && (x >> 2) <= r[15:8]
                        && (y >> 2) >= r[23:16] && (y >> 2) <= r[7:0] && cnt[cls - 1] < 255)
                        cnt[cls - 1]++;
                end
            end
            dx   = r[15:8] - r[31:24];
            dy   = r[7:0] - r[23:16];
            red  = cnt[0] > COLOR_AREA_MIN;
            wide = dx >= dy;
            tall = dx + TALL_MARGIN <= dy;
            if (red && tall)                   lbl = 4'd6;
            else if (cnt[1] > COLOR_AREA_MIN)  lbl = 4'd1;
            else if (cnt[2] > COLOR_AREA_MIN)  lbl = 4'd2;
            else if (cnt[3] > COLOR_AREA_MIN)  lbl = 4'd3;
            else if (red && cnt[4] > DARK_AREA_MIN) lbl = 4'd4;
            else if (red && wide)              lbl = 4'd5;
            else if (red)                      lbl = 4'd7;
            else                               lbl = 4'd0;
            exp_labels[k*4 +: 4] = lbl;
            m_num   = m_num + amount_t'(lbl != 4'd0);
            m_money = m_money + item_price(lbl);
        end
    endtask

    task automatic run_frame(int scene, user_t user);
        color_class_t cls;
        int           waited;
        if (timed_out)
            return;
        build_model(scene);
        frames_sent++;
        for (int y = 0; y < FH; y++) begin
            for (int x = 0; x < FW; x++) begin
                if (x >= WIN_LO && x <= WIN_HI && y >= WIN_LO && y <= WIN_HI)
                    cls = scene_class(scene, x, y);
                else
                    random_class(cls);
                @(posedge sys_clk);
                if (x == 0 && y == 0) begin
                    for (int k = 0; k < NR; k++)
                        i_rects[k*32 +: 32] <= rect_of(scene, k);
                    i_user <= user;
                end
                i_valid <= 1'b1;
                i_class <= cls;
            end
        end
        @(posedge sys_clk);
        i_valid <= 1'b0;
        waited = 0;
        while (tally_cnt < frames_sent && waited < TIMEOUT) begin
            @(posedge sys_clk);
            waited++;
        end
        if (tally_cnt < frames_sent) begin
            timed_out = 1'b1;
            timeouts++;
            $display("timeout: frame %0d gave no tally within %0d cycles", frames_sent, TIMEOUT);
        end
    endtask

    task automatic expect_out(string name, checkout_state_t st, amount_t num, amount_t money,
                              amount_t pay, user_t usr);
        if (timed_out)
            return;
        @(posedge sys_clk);
        test_name = name;
        exp_state   <= st;
        exp_num     <= num;
        exp_money   <= money;
        exp_payment <= pay;
        exp_user    <= usr;
        check_en    <= 1'b1;
        repeat (4) @(posedge sys_clk);
        check_en <= 1'b0;
        @(posedge sys_clk);
    endtask

    initial begin
        amount_t shown_num;
        amount_t shown_money;
        amount_t saved_num;
        amount_t saved_money;
        amount_t pay;
        sys_clk     = 1'b0;
        sys_rst_n   = 1'b0;
        i_valid     = 1'b0;
        i_class     = CLS_NONE;
        i_rects     = '0;
        i_user      = '0;
        lfsr        = 16'd81;
        check_en    = 1'b0;
        timed_out   = 1'b0;
        exp_labels  = '0;
        frames_sent = 0;
        mismatches  = 0;
        timeouts    = 0;
        shown_num   = '0;
        shown_money = '0;
        repeat (2) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        expect_out("reset", ST_FREE, 8'd0, 8'd0, 8'd0, 8'd0);

        //******************************************************************
        // unstable count until warning, then hold back to free
        //******************************************************************
        for (int i = 0; i < 3; i++) begin
            run_frame(SC_FULL, 8'h00);
            expect_out("warn", ST_FREE, shown_num, shown_money, 8'd0, 8'd0);
        end
        run_frame(SC_FULL, 8'h00);
        shown_num   = m_num;
        shown_money = m_money;
        expect_out("warn", ST_WARN, shown_num, shown_money, 8'd0, 8'd0);
        run_frame(SC_FULL, 8'h00);
        shown_num = m_num;
        expect_out("hold", ST_FREE, shown_num, shown_money, 8'd0, 8'd0);

        //******************************************************************
        // purchase of one item
        //******************************************************************
        run_frame(SC_FULL, 8'h5A);
        saved_num   = shown_num;
        saved_money = shown_money;
        expect_out("purchase", ST_GET, shown_num, shown_money, 8'd0, 8'h5A);
        run_frame(SC_TAKEN, 8'h00);
        pay = saved_money - m_money;
        expect_out("purchase", ST_PAY, saved_num, saved_money, pay, 8'h5A);
        run_frame(SC_TAKEN, 8'h00);
        shown_num = m_num;
        expect_out("purchase", ST_FREE, shown_num, saved_money, pay, 8'h00);
        run_frame(SC_TAKEN, 8'h00);
        shown_money = m_money;
        expect_out("purchase", ST_FREE, shown_num, shown_money, 8'd0, 8'h00);

        // restock puts the item back
        run_frame(SC_TAKEN, 8'hFF);
        expect_out("restock", ST_PUT, shown_num, shown_money, 8'd0, 8'h00);
        run_frame(SC_FULL, 8'hFF);
        expect_out("restock", ST_PUT, shown_num, shown_money, 8'd0, 8'h00);
        run_frame(SC_FULL, 8'h00);
        shown_num = m_num;
        expect_out("restock", ST_FREE, shown_num, shown_money, 8'd0, 8'h00);

        // second label set, counter only moves
        run_frame(SC_MIXED, 8'h00);
        expect_out("labels", ST_FREE, shown_num, shown_money, 8'd0, 8'h00);

        $display("errors: mismatches %0d, timeouts %0d", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* flist.f */
design/shelf_pkg.sv
design/pix_if.sv
design/label_if.sv
design/frame_scan.sv
design/item_grader.sv
design/label_tally.sv
design/checkout_fsm.sv
design/shelf_top.sv
testbench/tb_shelf.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_shelf -f flist.f -o tb_shelf_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_shelf_sim > sim.log 2>&1
grep -q "Simulation failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Simulation completed successfully" sim.log && echo "PASS" \
    || { echo "FAIL, no result in sim.log"; exit 1; }
